// File: hw/drive_params.svh
`ifndef DRIVE_PARAMS_SVH
`define DRIVE_PARAMS_SVH

// UART bit period in clock cycles
// Kept short so a simulated frame stays cheap
// A 50 MHz board at 115200 baud would use 434
`define DRV_CLKS_PER_BIT 8

// FIFO entries between frame generator and transmitter
// Large enough for one full frame, so the producer rarely stalls
`define DRV_FIFO_DEPTH 32

// Longest JSON frame in bytes, LEFT and RIGHT including the line feed
`define DRV_MAX_FRAME 27

`endif

// File: hw/drive_pkg.sv
`default_nettype none

package drive_pkg;

    // Drive command codes as seen on the cmd input
    typedef enum logic [2:0] {
        STOP  = 3'd0,  // Both wheels still
        LEFT  = 3'd1,  // Spin left
        RIGHT = 3'd2,  // Spin right
        FAST  = 3'd3,  // Straight, half speed
        SLOW  = 3'd4   // Straight, quarter speed
    } drive_cmd_t;

    // Byte count of one frame, up to 31
    typedef logic [4:0] frame_len_t;

    // Raw code to command, spare codes fall back to STOP
    function automatic drive_cmd_t decode_cmd(input logic [2:0] code);
        drive_cmd_t c;
        case (code)
            3'd1:    c = LEFT;
            3'd2:    c = RIGHT;
            3'd3:    c = FAST;
            3'd4:    c = SLOW;
            default: c = STOP;  // 0 and 5 to 7
        endcase
        return c;
    endfunction

    // Frame length per command, line feed included
    function automatic frame_len_t frame_len(input drive_cmd_t c);
        frame_len_t n;
        case (c)
            LEFT:    n = 5'd27;
            RIGHT:   n = 5'd27;
            FAST:    n = 5'd24;
            SLOW:    n = 5'd26;
            default: n = 5'd20;  // STOP
        endcase
        return n;
    endfunction

endpackage

`default_nettype wire

// File: hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // One character on the serial line
    typedef logic [7:0] uart_byte_t;

    // FIFO entry, a byte plus the end of frame marker
    typedef struct packed {
        logic       last;  // Set on the frame's final byte
        uart_byte_t data;  // Character to send
    } tx_entry_t;

    // Transmitter FSM states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // Line high, waiting for data
        START = 2'd1,  // Start bit, line low
        DATA  = 2'd2,  // Eight data bits, LSB first
        STOP  = 2'd3   // Stop bit, line high
    } tx_state_t;

endpackage

`default_nettype wire

// File: hw/byte_stream_if.sv
`default_nettype none
`timescale 1ns/100ps

// Byte path from frame generator through FIFO to transmitter
interface byte_stream_if;

    logic                  push;       // Write strobe, only while full is low
    uart_pkg::uart_byte_t  push_data;  // Byte written on push
    logic                  push_last;  // Byte closes the frame
    logic                  full;       // No free entry
    logic                  empty;      // No entry to pop
    logic                  pop;        // Remove head entry, only while empty is low
    uart_pkg::tx_entry_t   pop_data;   // Head entry, valid while empty is low

    // Frame generator side
    modport producer (output push, push_data, push_last, input full);

    // FIFO itself
    modport buffer (
        input  push, push_data, push_last, pop,
        output full, empty, pop_data
    );

    // UART transmitter side
    modport consumer (output pop, input empty, pop_data);

endinterface

`default_nettype wire

// File: hw/json_frame_gen.sv
`default_nettype none
`timescale 1ns/100ps
`include "drive_params.svh"

module json_frame_gen (
    input  logic                clk,
    input  logic                rst,
    input  logic [2:0]          cmd,   // Raw drive command code
    input  logic                send,  // One cycle request for a frame
    byte_stream_if.producer     bs,
    input  logic                done,  // Frame fully on the line from uart_tx
    output logic                busy
);

    // Frame texts right aligned so byte i sits at (len-1-i)*8
    localparam logic [8*`DRV_MAX_FRAME-1:0] text_stop  =
        "{\"T\":1,\"L\":0,\"R\":0}\n";
    localparam logic [8*`DRV_MAX_FRAME-1:0] text_left  =
        "{\"T\":1,\"L\":-0.25,\"R\":0.25}\n";
    localparam logic [8*`DRV_MAX_FRAME-1:0] text_right =
        "{\"T\":1,\"L\":0.25,\"R\":-0.25}\n";
    localparam logic [8*`DRV_MAX_FRAME-1:0] text_fast  =
        "{\"T\":1,\"L\":0.5,\"R\":0.5}\n";
    localparam logic [8*`DRV_MAX_FRAME-1:0] text_slow  =
        "{\"T\":1,\"L\":0.25,\"R\":0.25}\n";

    drive_pkg::drive_cmd_t  cmd_q;     // Command of the frame in flight
    drive_pkg::frame_len_t  idx;       // Next byte to push
    drive_pkg::frame_len_t  len;       // Length of current frame
    drive_pkg::frame_len_t  last_idx;  // Index of the line feed
    logic                   sending;   // Bytes still to push
    logic                   busy_q;    // Frame accepted and done not yet seen
    logic                   accept;    // Send taken this cycle
    logic                   is_last;

    // Byte lookup with one text per command
    function automatic uart_pkg::uart_byte_t frame_byte(
        input drive_pkg::drive_cmd_t c,
        input drive_pkg::frame_len_t i
    );
        logic [8*`DRV_MAX_FRAME-1:0] text;
        int                          pos;
        case (c)
            drive_pkg::LEFT:  text = text_left;
            drive_pkg::RIGHT: text = text_right;
            drive_pkg::FAST:  text = text_fast;
            drive_pkg::SLOW:  text = text_slow;
            default:          text = text_stop;
        endcase
        pos = (int'(drive_pkg::frame_len(c)) - 1 - int'(i)) * 8;
        return text[pos +: 8];
    endfunction

    assign len      = drive_pkg::frame_len(cmd_q);
    assign last_idx = len - 5'd1;
    assign is_last  = (idx == last_idx);

    // Done drops busy in the same cycle so a new send may follow at once
    assign busy   = busy_q & ~done;
    assign accept = send & ~busy;

    // Push side of the FIFO
    assign bs.push      = sending & ~bs.full;  // Stall on full
    assign bs.push_data = frame_byte(cmd_q, idx);
    assign bs.push_last = is_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_q   <= drive_pkg::STOP;
            idx     <= '0;
            sending <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            if (accept) begin
                cmd_q   <= drive_pkg::decode_cmd(cmd);  // Spare codes become STOP
                idx     <= '0;
                sending <= 1'b1;
                busy_q  <= 1'b1;
            end else begin
                if (done) begin
                    busy_q <= 1'b0;  // Last stop bit has left
                end
                if (sending && !bs.full) begin
                    if (is_last) begin
                        sending <= 1'b0;  // Whole frame queued
                    end else begin
                        idx <= idx + 5'd1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/byte_fifo.sv
`default_nettype none
`timescale 1ns/100ps
`include "drive_params.svh"

module byte_fifo #(
    parameter type payload_t = uart_pkg::tx_entry_t,
    parameter int  depth     = `DRV_FIFO_DEPTH
) (
    input  logic           clk,
    input  logic           rst,
    byte_stream_if.buffer  bs
);

    localparam int aw = $clog2(depth);      // Pointer width
    localparam int cw = $clog2(depth + 1);  // Count width, holds depth itself

    payload_t        mem [depth];  // Entry storage
    logic [aw-1:0]   wr_ptr;
    logic [aw-1:0]   rd_ptr;
    logic [cw-1:0]   count;        // Entries held
    logic            do_push;
    logic            do_pop;

    assign bs.full     = (count == cw'(depth));
    assign bs.empty    = (count == '0);
    assign bs.pop_data = mem[rd_ptr];  // Head always visible

    assign do_push = bs.push & ~bs.full;
    assign do_pop  = bs.pop & ~bs.empty;

    // Byte and marker packed into one entry
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= payload_t'({bs.push_last, bs.push_data});
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`default_nettype none
`timescale 1ns/100ps
`include "drive_params.svh"

module uart_tx (
    input  logic             clk,
    input  logic             rst,
    byte_stream_if.consumer  bs,
    output logic             txd,   // Serial line, idles high
    output logic             done   // One cycle after the frame's last stop bit
);

    localparam int tw = $clog2(`DRV_CLKS_PER_BIT);

    uart_pkg::tx_state_t   state;
    logic [tw-1:0]         timer;     // Cycles within a bit
    logic [2:0]            bit_cnt;   // Data bit number
    uart_pkg::uart_byte_t  shift;     // Remaining data bits
    logic                  last_q;    // Current byte ends the frame
    logic                  bit_end;   // Final cycle of a bit

    assign bit_end = (timer == tw'(`DRV_CLKS_PER_BIT - 1));

    // Take the head entry as soon as the line is free
    assign bs.pop = (state == uart_pkg::IDLE) & ~bs.empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= uart_pkg::IDLE;
            timer   <= '0;
            bit_cnt <= '0;
            shift   <= '0;
            last_q  <= 1'b0;
            txd     <= 1'b1;  // Idle line
            done    <= 1'b0;
        end else begin
            done  <= 1'b0;
            timer <= bit_end ? '0 : timer + 1'b1;
            case (state)
                uart_pkg::IDLE: begin
                    timer <= '0;
                    if (!bs.empty) begin
                        shift  <= bs.pop_data.data;
                        last_q <= bs.pop_data.last;
                        txd    <= 1'b0;  // Start bit
                        state  <= uart_pkg::START;
                    end
                end
                uart_pkg::START: begin
                    if (bit_end) begin
                        txd     <= shift[0];  // LSB first
                        shift   <= shift >> 1;
                        bit_cnt <= '0;
                        state   <= uart_pkg::DATA;
                    end
                end
                uart_pkg::DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            txd   <= 1'b1;  // Stop bit
                            state <= uart_pkg::STOP;
                        end else begin
                            txd     <= shift[0];
                            shift   <= shift >> 1;
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end
                default: begin  // STOP
                    if (bit_end) begin
                        done  <= last_q;  // Frame finished
                        state <= uart_pkg::IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/json_uart_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "drive_params.svh"

module json_uart_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  cmd,   // Drive command code
    input  logic        send,  // Request one frame
    output logic        txd,   // UART line out
    output logic        busy,  // Frame in progress
    output logic        done   // Frame sent
);

    logic tx_done;  // Shared by generator and top port

    byte_stream_if bs0 ();

    // Builds the JSON bytes for the latched command
    json_frame_gen gen0 (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd),
        .send (send),
        .bs   (bs0.producer),
        .done (tx_done),
        .busy (busy)
    );

    // Holds bytes with their end of frame marks
    byte_fifo #(
        .payload_t (uart_pkg::tx_entry_t),
        .depth     (`DRV_FIFO_DEPTH)
    ) fifo0 (
        .clk (clk),
        .rst (rst),
        .bs  (bs0.buffer)
    );

    // 8N1 serializer
    uart_tx tx0 (
        .clk  (clk),
        .rst  (rst),
        .bs   (bs0.consumer),
        .txd  (txd),
        .done (tx_done)
    );

    assign done = tx_done;

endmodule

`default_nettype wire

// File: tb/tb_json_uart.sv
`default_nettype none
`timescale 1ns/100ps
`include "drive_params.svh"

module tb_json_uart;

    localparam int cpb      = `DRV_CLKS_PER_BIT;
    localparam int mem_size = 512;

    logic                  clk;
    logic                  rst;
    logic [2:0]            cmd;
    logic                  send;
    logic                  txd;
    logic                  busy;
    logic                  done;

    logic [7:0]            stim [mem_size];  // Raw words of the data file
    uart_pkg::uart_byte_t  rx_q [$];         // Bytes rebuilt from txd
    uart_pkg::uart_byte_t  rx_byte;          // Byte being sampled
    int                    done_cnt;         // Done pulses seen so far
    int                    ntests;
    logic                  loaded;           // Test count known
    integer                seed;

    json_uart_top dut0 (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd),
        .send (send),
        .txd  (txd),
        .busy (busy),
        .done (done)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input uart_pkg::uart_byte_t got,
                              input uart_pkg::uart_byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input drive_pkg::frame_len_t got,
                             input drive_pkg::frame_len_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // One cycle send strobe with a command code
    task automatic send_cmd(input logic [2:0] code);
        @(posedge clk);
        cmd  <= code;
        send <= 1'b1;
        @(posedge clk);
        send <= 1'b0;  // DUT takes it on this edge
    endtask

    // UART receiver, samples near the middle of each bit
    always begin
        @(negedge txd);
        if (!rst) begin
            repeat (cpb / 2) @(negedge clk);
            check_level("txd start bit", txd, 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (cpb) @(negedge clk);
                rx_byte[i] = txd;  // LSB first
            end
            repeat (cpb) @(negedge clk);
            check_level("txd stop bit", txd, 1'b1);
            rx_q.push_back(rx_byte);
        end
    end

    // Counts every done pulse, stray ones included
    always @(negedge clk) begin
        if (!rst && done) begin
            done_cnt++;
        end
    end

    // Watchdog sized from the number of tests
    initial begin
        longint limit;
        wait (loaded === 1'b1);
        limit = longint'(ntests) * `DRV_MAX_FRAME * 10 * cpb * 4 * 2;
        #(limit);
        abort_run("Timeout: the frames did not finish in the expected time");
    end

    initial begin
        int                     p;
        int                     gap;
        logic [2:0]             code;
        drive_pkg::frame_len_t  len;
        clk      = 1'b0;
        rst      = 1'b1;
        cmd      = 3'd0;
        send     = 1'b0;
        seed     = 15789;
        done_cnt = 0;
        loaded   = 1'b0;
        $readmemh("tb/tb_input.txt", stim);
        ntests = int'(stim[0]);  // Word 0 is the test count
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_level("txd after reset", txd, 1'b1);  // Idle line
        check_level("busy after reset", busy, 1'b0);
        check_level("done after reset", done, 1'b0);

        p = 1;
        for (int t = 0; t < ntests; t++) begin
            code = stim[p][2:0];
            len  = drive_pkg::frame_len_t'(stim[p + 1]);
            gap  = $random(seed) & 3;  // Zero gives a send right after done
            repeat (gap) @(posedge clk);
            send_cmd(code);
            @(negedge clk);
            check_level("busy after send", busy, 1'b1);

            // Second send in the middle of a frame, must be dropped
            if (t % 3 == 1) begin
                repeat (3 * cpb) @(negedge clk);
                check_level("busy before extra send", busy, 1'b1);
                send_cmd(code ^ 3'd1);
            end

            while (done !== 1'b1) begin
                @(negedge clk);
            end
            check_level("busy with done", busy, 1'b0);  // Falls with done
            if (rx_q.size() > `DRV_MAX_FRAME) begin
                abort_run($sformatf("Test %0d received more bytes than any frame has", t));
            end
            check_len($sformatf("frame length of test %0d", t),
                      drive_pkg::frame_len_t'(rx_q.size()), len);
            for (int i = 0; i < int'(len); i++) begin
                check_byte($sformatf("txd byte %0d of test %0d", i, t),
                           rx_q[i], stim[p + 2 + i]);
            end
            rx_q.delete();
            @(negedge clk);
            check_level("done one cycle", done, 1'b0);
            check_count("done pulses", done_cnt, t + 1);
            p = p + 2 + int'(len);
        end

        // Quiet tail, nothing more may arrive
        repeat (20 * cpb) @(negedge clk);
        check_count("bytes after last frame", rx_q.size(), 0);
        check_count("done pulses at end", done_cnt, ntests);
        check_level("busy at end", busy, 1'b0);
        check_level("txd at end", txd, 1'b1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_input.txt
// Word 0: number of tests
// Each test line: command code, frame length, then the frame bytes, all in hex
0c
// STOP, LEFT, RIGHT, FAST, SLOW
00 14 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2c 22 52 22 3a 30 7d 0a
01 1b 7b 22 54 22 3a 31 2c 22 4c 22 3a 2d 30 2e 32 35 2c 22 52 22 3a 30 2e 32 35 7d 0a
02 1b 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 32 35 2c 22 52 22 3a 2d 30 2e 32 35 7d 0a
03 18 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 35 2c 22 52 22 3a 30 2e 35 7d 0a
04 1a 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 32 35 2c 22 52 22 3a 30 2e 32 35 7d 0a
// Spare codes fall back to STOP
05 14 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2c 22 52 22 3a 30 7d 0a
06 14 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2c 22 52 22 3a 30 7d 0a
07 14 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2c 22 52 22 3a 30 7d 0a
// Repeats in another order
01 1b 7b 22 54 22 3a 31 2c 22 4c 22 3a 2d 30 2e 32 35 2c 22 52 22 3a 30 2e 32 35 7d 0a
03 18 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 35 2c 22 52 22 3a 30 2e 35 7d 0a
04 1a 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 32 35 2c 22 52 22 3a 30 2e 32 35 7d 0a
02 1b 7b 22 54 22 3a 31 2c 22 4c 22 3a 30 2e 32 35 2c 22 52 22 3a 2d 30 2e 32 35 7d 0a

// File: files.f
+incdir+hw
hw/drive_pkg.sv
hw/uart_pkg.sv
hw/byte_stream_if.sv
hw/json_frame_gen.sv
hw/byte_fifo.sv
hw/uart_tx.sv
hw/json_uart_top.sv
tb/tb_json_uart.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the failure line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_json_uart \
    -o tb_json_uart > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_json_uart > sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log && echo "PASS" || {
    echo "FAIL, no result in sim.log"
    exit 1
}
